//--- source/mips_mem_consts.svh
`ifndef MIPS_MEM_CONSTS_SVH
`define MIPS_MEM_CONSTS_SVH

// data bus and register width.
`define MEM_DATA_W 32

// byte address width, covers the whole memory.
`define MEM_ADDR_W 10

// memory size in bytes.
`define MEM_BYTES 1024

// one select per byte lane.
`define MEM_SEL_W 4

`endif

//--- source/mips_mem_pkg.sv
`include "mips_mem_consts.svh"

package mips_mem_pkg;

    // access width of a load or store.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    // data as it travels on the bus and in the core.
    typedef logic [`MEM_DATA_W-1:0] word_t;

    // byte address as issued by the core.
    typedef logic [`MEM_ADDR_W-1:0] byte_addr_t;

    // byte lane selects.
    typedef logic [`MEM_SEL_W-1:0] sel_t;

endpackage

//--- source/lsu_port.sv
`timescale 1ns/10ps
`include "mips_mem_consts.svh"

module lsu_port (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_req,
    input  logic                       i_we,
    input  mips_mem_pkg::access_size_t i_size,
    input  logic                       i_signed,
    input  mips_mem_pkg::byte_addr_t   i_addr,
    input  mips_mem_pkg::word_t        i_wdata,
    output logic                       o_busy,
    output logic                       o_done,
    output mips_mem_pkg::word_t        o_rdata,
    output logic                       o_misaligned,
    output logic                       o_wb_cyc,
    output logic                       o_wb_stb,
    output logic                       o_wb_we,
    output logic [`MEM_ADDR_W-3:0]     o_wb_adr,
    output mips_mem_pkg::word_t        o_wb_dat,
    output mips_mem_pkg::sel_t         o_wb_sel,
    input  mips_mem_pkg::word_t        i_wb_dat,
    input  logic                       i_wb_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_DONE
    } state_t;

    state_t state_q;

    // request as captured at acceptance.
    logic                       we_q;
    mips_mem_pkg::access_size_t size_q;
    logic                       signed_q;
    logic [1:0]                 lane_q;
    logic [`MEM_ADDR_W-3:0]     adr_q;
    mips_mem_pkg::word_t        wdat_q;
    mips_mem_pkg::sel_t         sel_q;

    logic                accept;
    logic                aligned;
    mips_mem_pkg::sel_t  sel_d;
    mips_mem_pkg::word_t wdat_d;
    mips_mem_pkg::word_t lane_data;
    mips_mem_pkg::word_t load_data;

    // a new request is taken whenever no bus cycle is running.
    assign accept = i_req && (state_q != ST_BUS);

    // alignment check, lane selects and write data placement.
    always_comb begin
        case (i_size)
            mips_mem_pkg::SIZE_BYTE: begin
                aligned = 1'b1;
                sel_d   = mips_mem_pkg::sel_t'(4'b0001 << i_addr[1:0]);
                wdat_d  = mips_mem_pkg::word_t'(i_wdata[7:0]) << {i_addr[1:0], 3'b000};
            end
            mips_mem_pkg::SIZE_HALF: begin
                aligned = ~i_addr[0];
                sel_d   = i_addr[1] ? 4'b1100 : 4'b0011;
                wdat_d  = mips_mem_pkg::word_t'(i_wdata[15:0]) << {i_addr[1], 4'b0000};
            end
            default: begin
                aligned = (i_addr[1:0] == 2'b00);
                sel_d   = 4'b1111;
                wdat_d  = i_wdata;
            end
        endcase
    end

    // bring the addressed lane down to bit 0, then extend.
    assign lane_data = i_wb_dat >> {lane_q, 3'b000};

    always_comb begin
        case (size_q)
            mips_mem_pkg::SIZE_BYTE: begin
                if (signed_q) begin
                    load_data = {{24{lane_data[7]}}, lane_data[7:0]};
                end else begin
                    load_data = {24'b0, lane_data[7:0]};
                end
            end
            mips_mem_pkg::SIZE_HALF: begin
                if (signed_q) begin
                    load_data = {{16{lane_data[15]}}, lane_data[15:0]};
                end else begin
                    load_data = {16'b0, lane_data[15:0]};
                end
            end
            default: load_data = i_wb_dat;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q      <= ST_IDLE;
            o_misaligned <= 1'b0;
        end else begin
            o_misaligned <= accept && !aligned;
            case (state_q)
                ST_BUS: begin
                    if (i_wb_ack) begin
                        state_q <= ST_DONE;
                    end
                end
                default: begin
                    if (accept) begin
                        // misaligned requests skip the bus entirely.
                        state_q <= aligned ? ST_BUS : ST_DONE;
                    end else begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // payload and result registers.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            we_q     <= i_we;
            size_q   <= i_size;
            signed_q <= i_signed;
            lane_q   <= i_addr[1:0];
            adr_q    <= i_addr[`MEM_ADDR_W-1:2];
            wdat_q   <= wdat_d;
            sel_q    <= sel_d;
            if (!aligned) begin
                o_rdata <= '0;
            end
        end
        if (state_q == ST_BUS && i_wb_ack) begin
            o_rdata <= we_q ? '0 : load_data;
        end
    end

    assign o_busy   = (state_q == ST_BUS);
    assign o_done   = (state_q == ST_DONE);
    assign o_wb_cyc = (state_q == ST_BUS);
    assign o_wb_stb = (state_q == ST_BUS);
    assign o_wb_we  = we_q;
    assign o_wb_adr = adr_q;
    assign o_wb_dat = wdat_q;
    assign o_wb_sel = sel_q;

endmodule

//--- source/wb_arbiter.sv
`timescale 1ns/10ps
`include "mips_mem_consts.svh"

module wb_arbiter (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_m0_cyc,
    input  logic                   i_m0_stb,
    input  logic                   i_m0_we,
    input  logic [`MEM_ADDR_W-3:0] i_m0_adr,
    input  mips_mem_pkg::word_t    i_m0_dat,
    input  mips_mem_pkg::sel_t     i_m0_sel,
    output mips_mem_pkg::word_t    o_m0_dat,
    output logic                   o_m0_ack,
    input  logic                   i_m1_cyc,
    input  logic                   i_m1_stb,
    input  logic                   i_m1_we,
    input  logic [`MEM_ADDR_W-3:0] i_m1_adr,
    input  mips_mem_pkg::word_t    i_m1_dat,
    input  mips_mem_pkg::sel_t     i_m1_sel,
    output mips_mem_pkg::word_t    o_m1_dat,
    output logic                   o_m1_ack,
    output logic                   o_s_cyc,
    output logic                   o_s_stb,
    output logic                   o_s_we,
    output logic [`MEM_ADDR_W-3:0] o_s_adr,
    output mips_mem_pkg::word_t    o_s_dat,
    output mips_mem_pkg::sel_t     o_s_sel,
    input  mips_mem_pkg::word_t    i_s_dat,
    input  logic                   i_s_ack
);

    // owner of the previous cycle and winner of the last tie-break.
    logic owner_q;
    logic last_q;

    logic active;
    logic new_grant;
    logic grant;

    // the bus stays with its owner as long as that master keeps cyc up.
    assign active = owner_q ? i_m1_cyc : i_m0_cyc;

    always_comb begin
        if (active) begin
            grant = owner_q;
        end else if (i_m0_cyc && i_m1_cyc) begin
            grant = ~last_q;
        end else begin
            grant = i_m1_cyc;
        end
    end

    assign new_grant = !active && (i_m0_cyc || i_m1_cyc);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            owner_q <= 1'b0;
            last_q  <= 1'b1;
        end else begin
            owner_q <= grant;
            if (new_grant) begin
                last_q <= grant;
            end
        end
    end

    // request mux towards the slave.
    assign o_s_cyc = grant ? i_m1_cyc : i_m0_cyc;
    assign o_s_stb = grant ? i_m1_stb : i_m0_stb;
    assign o_s_we  = grant ? i_m1_we  : i_m0_we;
    assign o_s_adr = grant ? i_m1_adr : i_m0_adr;
    assign o_s_dat = grant ? i_m1_dat : i_m0_dat;
    assign o_s_sel = grant ? i_m1_sel : i_m0_sel;

    // response only to the granted master.
    assign o_m0_ack = i_s_ack && !grant;
    assign o_m1_ack = i_s_ack && grant;
    assign o_m0_dat = grant ? '0 : i_s_dat;
    assign o_m1_dat = grant ? i_s_dat : '0;

endmodule

//--- source/data_memory.sv
`timescale 1ns/10ps
`include "mips_mem_consts.svh"

module data_memory (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_wb_cyc,
    input  logic                   i_wb_stb,
    input  logic                   i_wb_we,
    input  logic [`MEM_ADDR_W-3:0] i_wb_adr,
    input  mips_mem_pkg::word_t    i_wb_dat,
    input  mips_mem_pkg::sel_t     i_wb_sel,
    output mips_mem_pkg::word_t    o_wb_dat,
    output logic                   o_wb_ack
);

    localparam int DEPTH = `MEM_BYTES / 4;

    logic access;

    // one access per strobe, the registered ack adds the wait state.
    assign access = i_wb_cyc && i_wb_stb && !o_wb_ack;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= access;
        end
    end

    // little-endian lanes, lane 0 holds the byte at the lowest address.
    for (genvar l = 0; l < `MEM_SEL_W; l++) begin : g_lane
        logic [7:0] lane_mem [DEPTH];

        always_ff @(posedge i_clk) begin
            if (access) begin
                if (i_wb_we && i_wb_sel[l]) begin
                    lane_mem[i_wb_adr] <= i_wb_dat[8*l +: 8];
                end
                o_wb_dat[8*l +: 8] <= lane_mem[i_wb_adr];
            end
        end
    end

endmodule

//--- source/mem_subsys_top.sv
`timescale 1ns/10ps
`include "mips_mem_consts.svh"

module mem_subsys_top (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_p0_req,
    input  logic                       i_p0_we,
    input  mips_mem_pkg::access_size_t i_p0_size,
    input  logic                       i_p0_signed,
    input  mips_mem_pkg::byte_addr_t   i_p0_addr,
    input  mips_mem_pkg::word_t        i_p0_wdata,
    output logic                       o_p0_busy,
    output logic                       o_p0_done,
    output mips_mem_pkg::word_t        o_p0_rdata,
    output logic                       o_p0_misaligned,
    input  logic                       i_p1_req,
    input  logic                       i_p1_we,
    input  mips_mem_pkg::access_size_t i_p1_size,
    input  logic                       i_p1_signed,
    input  mips_mem_pkg::byte_addr_t   i_p1_addr,
    input  mips_mem_pkg::word_t        i_p1_wdata,
    output logic                       o_p1_busy,
    output logic                       o_p1_done,
    output mips_mem_pkg::word_t        o_p1_rdata,
    output logic                       o_p1_misaligned
);

    // core side master link.
    logic                   m0_cyc;
    logic                   m0_stb;
    logic                   m0_we;
    logic [`MEM_ADDR_W-3:0] m0_adr;
    mips_mem_pkg::word_t    m0_dat_w;
    mips_mem_pkg::sel_t     m0_sel;
    mips_mem_pkg::word_t    m0_dat_r;
    logic                   m0_ack;

    // debug and loader master link.
    logic                   m1_cyc;
    logic                   m1_stb;
    logic                   m1_we;
    logic [`MEM_ADDR_W-3:0] m1_adr;
    mips_mem_pkg::word_t    m1_dat_w;
    mips_mem_pkg::sel_t     m1_sel;
    mips_mem_pkg::word_t    m1_dat_r;
    logic                   m1_ack;

    // arbitrated link into the memory.
    logic                   s_cyc;
    logic                   s_stb;
    logic                   s_we;
    logic [`MEM_ADDR_W-3:0] s_adr;
    mips_mem_pkg::word_t    s_dat_w;
    mips_mem_pkg::sel_t     s_sel;
    mips_mem_pkg::word_t    s_dat_r;
    logic                   s_ack;

    lsu_port port0 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req        (i_p0_req),
        .i_we         (i_p0_we),
        .i_size       (i_p0_size),
        .i_signed     (i_p0_signed),
        .i_addr       (i_p0_addr),
        .i_wdata      (i_p0_wdata),
        .o_busy       (o_p0_busy),
        .o_done       (o_p0_done),
        .o_rdata      (o_p0_rdata),
        .o_misaligned (o_p0_misaligned),
        .o_wb_cyc     (m0_cyc),
        .o_wb_stb     (m0_stb),
        .o_wb_we      (m0_we),
        .o_wb_adr     (m0_adr),
        .o_wb_dat     (m0_dat_w),
        .o_wb_sel     (m0_sel),
        .i_wb_dat     (m0_dat_r),
        .i_wb_ack     (m0_ack)
    );

    lsu_port port1 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req        (i_p1_req),
        .i_we         (i_p1_we),
        .i_size       (i_p1_size),
        .i_signed     (i_p1_signed),
        .i_addr       (i_p1_addr),
        .i_wdata      (i_p1_wdata),
        .o_busy       (o_p1_busy),
        .o_done       (o_p1_done),
        .o_rdata      (o_p1_rdata),
        .o_misaligned (o_p1_misaligned),
        .o_wb_cyc     (m1_cyc),
        .o_wb_stb     (m1_stb),
        .o_wb_we      (m1_we),
        .o_wb_adr     (m1_adr),
        .o_wb_dat     (m1_dat_w),
        .o_wb_sel     (m1_sel),
        .i_wb_dat     (m1_dat_r),
        .i_wb_ack     (m1_ack)
    );

    wb_arbiter arb0 (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_m0_cyc (m0_cyc),
        .i_m0_stb (m0_stb),
        .i_m0_we  (m0_we),
        .i_m0_adr (m0_adr),
        .i_m0_dat (m0_dat_w),
        .i_m0_sel (m0_sel),
        .o_m0_dat (m0_dat_r),
        .o_m0_ack (m0_ack),
        .i_m1_cyc (m1_cyc),
        .i_m1_stb (m1_stb),
        .i_m1_we  (m1_we),
        .i_m1_adr (m1_adr),
        .i_m1_dat (m1_dat_w),
        .i_m1_sel (m1_sel),
        .o_m1_dat (m1_dat_r),
        .o_m1_ack (m1_ack),
        .o_s_cyc  (s_cyc),
        .o_s_stb  (s_stb),
        .o_s_we   (s_we),
        .o_s_adr  (s_adr),
        .o_s_dat  (s_dat_w),
        .o_s_sel  (s_sel),
        .i_s_dat  (s_dat_r),
        .i_s_ack  (s_ack)
    );

    data_memory mem0 (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wb_cyc (s_cyc),
        .i_wb_stb (s_stb),
        .i_wb_we  (s_we),
        .i_wb_adr (s_adr),
        .i_wb_dat (s_dat_w),
        .i_wb_sel (s_sel),
        .o_wb_dat (s_dat_r),
        .o_wb_ack (s_ack)
    );

endmodule

//--- tb/tb_mem_subsys.sv
`timescale 1ns/10ps
`include "mips_mem_consts.svh"

module tb_mem_subsys;

    localparam int CLK_PERIOD = 8;
    localparam int N_CONC = 32;
    // fill 256, round trip 32, lanes 48, extension 24, misaligned 32, concurrent 64, cross 16.
    localparam int N_REQUESTS = 472;

    logic clk;
    logic rst_n;

    logic [1:0]                 req;
    logic [1:0]                 we;
    logic [1:0]                 sgn;
    mips_mem_pkg::access_size_t size_in [2];
    mips_mem_pkg::byte_addr_t   addr_in [2];
    mips_mem_pkg::word_t        wdata_in [2];

    wire [1:0]                   busy;
    wire [1:0]                   done;
    wire [1:0]                   mis;
    wire [1:0][`MEM_DATA_W-1:0]  rdata;

    // reference image of the data memory with one entry per byte address.
    logic [7:0] model [`MEM_BYTES];

    integer seed;
    int     errors;
    int     tests_passed;
    int     tests_failed;
    int     wait_slack;

    logic                       conc_we [2][N_CONC];
    logic                       conc_sgn [2][N_CONC];
    mips_mem_pkg::access_size_t conc_size [2][N_CONC];
    int                         conc_addr [2][N_CONC];
    mips_mem_pkg::word_t        conc_wdata [2][N_CONC];

    mem_subsys_top dut0 (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_p0_req        (req[0]),
        .i_p0_we         (we[0]),
        .i_p0_size       (size_in[0]),
        .i_p0_signed     (sgn[0]),
        .i_p0_addr       (addr_in[0]),
        .i_p0_wdata      (wdata_in[0]),
        .o_p0_busy       (busy[0]),
        .o_p0_done       (done[0]),
        .o_p0_rdata      (rdata[0]),
        .o_p0_misaligned (mis[0]),
        .i_p1_req        (req[1]),
        .i_p1_we         (we[1]),
        .i_p1_size       (size_in[1]),
        .i_p1_signed     (sgn[1]),
        .i_p1_addr       (addr_in[1]),
        .i_p1_wdata      (wdata_in[1]),
        .o_p1_busy       (busy[1]),
        .o_p1_done       (done[1]),
        .o_p1_rdata      (rdata[1]),
        .o_p1_misaligned (mis[1])
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // a run that stalls on a request never reaches the report.
    initial begin
        #((N_REQUESTS * 20 + 10) * CLK_PERIOD);
        $display("run timed out after %0d cycles, a request never completed",
                 N_REQUESTS * 20 + 10);
        $display("TEST FAILED");
        $finish;
    end

    function automatic mips_mem_pkg::word_t fill_word(int idx);
        logic [7:0] w;
        w = idx[7:0];
        return {w, ~w, w ^ 8'h5a, w + 8'h33};
    endfunction

    function automatic logic is_aligned(mips_mem_pkg::access_size_t sz, int a);
        case (sz)
            mips_mem_pkg::SIZE_BYTE: return 1'b1;
            mips_mem_pkg::SIZE_HALF: return (a % 2) == 0;
            default:                 return (a % 4) == 0;
        endcase
    endfunction

    function automatic int align_addr(mips_mem_pkg::access_size_t sz, int a);
        case (sz)
            mips_mem_pkg::SIZE_BYTE: return a;
            mips_mem_pkg::SIZE_HALF: return a & ~1;
            default:                 return a & ~3;
        endcase
    endfunction

    function automatic mips_mem_pkg::access_size_t pick_size(bit with_word);
        int r;
        r = with_word ? {$random(seed)} % 3 : {$random(seed)} % 2;
        case (r)
            0:       return mips_mem_pkg::SIZE_BYTE;
            1:       return mips_mem_pkg::SIZE_HALF;
            default: return mips_mem_pkg::SIZE_WORD;
        endcase
    endfunction

    // little-endian load puts the lowest address in the low byte.
    function automatic mips_mem_pkg::word_t expected_load(mips_mem_pkg::access_size_t sz,
                                                          logic s, int a);
        logic [15:0] half;
        case (sz)
            mips_mem_pkg::SIZE_BYTE: begin
                if (s) begin
                    return {{24{model[a][7]}}, model[a]};
                end
                return {24'h0, model[a]};
            end
            mips_mem_pkg::SIZE_HALF: begin
                half = {model[a+1], model[a]};
                if (s) begin
                    return {{16{half[15]}}, half};
                end
                return {16'h0, half};
            end
            default: return {model[a+3], model[a+2], model[a+1], model[a]};
        endcase
    endfunction

    function automatic void model_write(mips_mem_pkg::access_size_t sz, int a,
                                        mips_mem_pkg::word_t wd);
        model[a] = wd[7:0];
        if (sz != mips_mem_pkg::SIZE_BYTE) begin
            model[a+1] = wd[15:8];
        end
        if (sz == mips_mem_pkg::SIZE_WORD) begin
            model[a+2] = wd[23:16];
            model[a+3] = wd[31:24];
        end
    endfunction

    // starts 1 ns after a rising edge and returns 1 ns after the edge that raised done.
    task automatic do_access(input int p, input logic w, input mips_mem_pkg::access_size_t sz,
                             input logic s, input int a, input mips_mem_pkg::word_t wd,
                             output mips_mem_pkg::word_t rd, output logic m, output int lat);
        while (busy[p]) begin
            @(posedge clk);
            #1;
        end
        we[p]       = w;
        size_in[p]  = sz;
        sgn[p]      = s;
        addr_in[p]  = a[`MEM_ADDR_W-1:0];
        wdata_in[p] = wd;
        req[p]      = 1'b1;
        @(posedge clk);
        #1;
        req[p] = 1'b0;
        lat    = 1;
        // busy covers every cycle between the request and done.
        while (!done[p]) begin
            if (!busy[p]) begin
                errors++;
                $display("[ERROR] %0t: port %0d busy low while waiting for done", $time, p);
            end
            @(posedge clk);
            #1;
            lat++;
        end
        if (busy[p]) begin
            errors++;
            $display("[ERROR] %0t: port %0d busy still high with done", $time, p);
        end
        rd = rdata[p];
        m  = mis[p];
    endtask

    task automatic check_access(input int p, input logic w,
                                input mips_mem_pkg::access_size_t sz, input logic s,
                                input int a, input mips_mem_pkg::word_t wd);
        mips_mem_pkg::word_t rd;
        mips_mem_pkg::word_t exp;
        logic                m;
        logic                ok_align;
        int                  lat;
        int                  min_lat;
        int                  max_lat;
        ok_align = is_aligned(sz, a);
        exp = (w || !ok_align) ? '0 : expected_load(sz, s, a);
        min_lat = ok_align ? 3 : 1;
        max_lat = ok_align ? 3 + wait_slack : 1;
        do_access(p, w, sz, s, a, wd, rd, m, lat);
        if (m !== !ok_align) begin
            errors++;
            $display("[ERROR] %0t: port %0d misaligned flag %b at 0x%03h, expected %b",
                     $time, p, m, a, !ok_align);
        end
        if (rd !== exp) begin
            errors++;
            $display("[ERROR] %0t: port %0d %s size %0d at 0x%03h gave 0x%08h, expected 0x%08h",
                     $time, p, w ? "store" : "load", sz, a, rd, exp);
        end
        if (lat < min_lat || lat > max_lat) begin
            errors++;
            $display("[ERROR] %0t: port %0d done %0d cycles after request, expected %0d to %0d",
                     $time, p, lat, min_lat, max_lat);
        end
        if (w && ok_align) begin
            model_write(sz, a, wd);
        end
    endtask

    task automatic run_traffic(input int p);
        for (int i = 0; i < N_CONC; i++) begin
            check_access(p, conc_we[p][i], conc_size[p][i], conc_sgn[p][i],
                         conc_addr[p][i], conc_wdata[p][i]);
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            tests_passed++;
            $display("%0t: %s passed", $time, name);
        end else begin
            tests_failed++;
            $display("%0t: %s failed with %0d errors", $time, name, errors - start_errors);
        end
    endtask

    initial begin
        int                         start;
        int                         a;
        int                         base;
        mips_mem_pkg::access_size_t sz;
        mips_mem_pkg::word_t        wd;
        int                         word_addrs [16];

        seed         = 32'hf0f1;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        wait_slack   = 0;
        rst_n        = 1'b0;
        req          = '0;
        we           = '0;
        sgn          = '0;
        for (int p = 0; p < 2; p++) begin
            size_in[p]  = mips_mem_pkg::SIZE_BYTE;
            addr_in[p]  = '0;
            wdata_in[p] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // loader port gives every word a pattern of its own address.
        start = errors;
        for (int i = 0; i < `MEM_BYTES / 4; i++) begin
            check_access(1, 1'b1, mips_mem_pkg::SIZE_WORD, 1'b0, 4 * i, fill_word(i));
        end
        finish_test("memory fill", start);

        start = errors;
        for (int i = 0; i < 16; i++) begin
            word_addrs[i] = $random(seed) & 'h1fc;
            check_access(0, 1'b1, mips_mem_pkg::SIZE_WORD, 1'b0, word_addrs[i], $random(seed));
        end
        for (int i = 0; i < 16; i++) begin
            check_access(0, 1'b0, mips_mem_pkg::SIZE_WORD, 1'b0, word_addrs[i], '0);
        end
        finish_test("word round trip", start);

        // the word read back shows which lanes moved.
        start = errors;
        for (int i = 0; i < 24; i++) begin
            sz = pick_size(1'b0);
            a  = align_addr(sz, $random(seed) & 'h1ff);
            check_access(0, 1'b1, sz, 1'b0, a, $random(seed));
            check_access(0, 1'b0, mips_mem_pkg::SIZE_WORD, 1'b0, a & ~3, '0);
        end
        finish_test("byte and halfword lanes", start);

        start = errors;
        for (int i = 0; i < 24; i++) begin
            sz = pick_size(1'b0);
            a  = align_addr(sz, $random(seed) & 'h3ff);
            check_access(0, 1'b0, sz, $random(seed) & 1, a, '0);
        end
        finish_test("load extension", start);

        start = errors;
        for (int i = 0; i < 16; i++) begin
            base = $random(seed) & 'h3fc;
            if ($random(seed) & 1) begin
                sz = mips_mem_pkg::SIZE_HALF;
                a  = base | 1 | ($random(seed) & 2);
            end else begin
                sz = mips_mem_pkg::SIZE_WORD;
                a  = base + 1 + {$random(seed)} % 3;
            end
            wd = $random(seed);
            check_access(0, $random(seed) & 1, sz, 1'b0, a, wd);
            check_access(0, 1'b0, mips_mem_pkg::SIZE_WORD, 1'b0, base, '0);
        end
        finish_test("misaligned rejection", start);

        // port 0 stays in the lower half and port 1 in the upper half.
        start = errors;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < N_CONC; i++) begin
                conc_we[p][i]    = $random(seed) & 1;
                conc_sgn[p][i]   = $random(seed) & 1;
                conc_size[p][i]  = pick_size(1'b1);
                conc_addr[p][i]  = align_addr(conc_size[p][i], p * 512 + ($random(seed) & 'h1ff));
                conc_wdata[p][i] = $random(seed);
            end
        end
        // a port that loses a tie waits for at most one bus cycle of the other port.
        wait_slack = 2;
        fork
            run_traffic(0);
            run_traffic(1);
        join
        wait_slack = 0;
        finish_test("concurrent ports", start);

        start = errors;
        for (int i = 0; i < 8; i++) begin
            a = $random(seed) & 'h3fc;
            check_access(1, 1'b1, mips_mem_pkg::SIZE_WORD, 1'b0, a, $random(seed));
            check_access(0, 1'b0, mips_mem_pkg::SIZE_WORD, 1'b0, a, '0);
        end
        finish_test("cross-port visibility", start);

        $display("summary: %0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+source
source/mips_mem_pkg.sv
source/lsu_port.sv
source/wb_arbiter.sv
source/data_memory.sv
source/mem_subsys_top.sv
tb/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mips_mem_subsys

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mips_mem_pkg.sv
      - source/lsu_port.sv
      - source/wb_arbiter.sv
      - source/data_memory.sv
      - source/mem_subsys_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - tb/tb_mem_subsys.sv
